//--- src.f
src/decode_pkg.sv
src/id_control.sv
src/operand_select.sv
src/id_ex_reg.sv
src/decode_stage.sv
testbench/decode_checker.sv
testbench/tb_decode_stage.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decode_stage -f src.f -o sim_decode \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_decode | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null \
    && { echo "result: passed"; exit 0; } \
    || { echo "result: failed"; exit 1; }

//--- testbench/tb_decode_stage.sv
module tb_decode_stage
    import decode_pkg::*;
();

    logic      clk;
    logic      rst_n;
    instr_t    pc_ins;
    word_t     rd1_data;
    word_t     rd2_data;
    logic      ex_en_wd;
    logic      mem_en_wd;
    reg_addr_t ex_des_addr;
    reg_addr_t mem_des_addr;
    word_t     ex_result;
    word_t     mem_result;
    logic      en_rd1;
    logic      en_rd2;
    reg_addr_t rd1_addr;
    reg_addr_t rd2_addr;
    word_t     num1;
    word_t     num2;
    alu_op_t   op;
    alu_sel_t  sel;
    logic      en_wd;
    reg_addr_t des_addr;

    logic      row_valid;  // a table row is on the inputs
    int        row_idx;
    logic      exp_en_rd1;
    logic      exp_en_rd2;
    reg_addr_t exp_rd1_addr;
    reg_addr_t exp_rd2_addr;
    word_t     exp_num1;
    word_t     exp_num2;
    alu_op_t   exp_op;
    alu_sel_t  exp_sel;
    logic      exp_en_wd;
    reg_addr_t exp_des_addr;
    int        error_count;
    int        check_count;
    bit        table_ready;

    // stimulus table, one entry per row
    instr_t     t_instr[$];
    logic       t_ex_en[$];
    reg_addr_t  t_ex_addr[$];
    word_t      t_ex_res[$];
    logic       t_mem_en[$];
    reg_addr_t  t_mem_addr[$];
    word_t      t_mem_res[$];
    logic [1:0] t_rd_en[$];  // {en_rd1, en_rd2}
    word_t      t_num1[$];
    word_t      t_num2[$];
    alu_op_t    t_op[$];
    alu_sel_t   t_sel[$];
    logic       t_wd[$];
    reg_addr_t  t_des[$];

    // forwarding state copied into each new row
    logic      fwd_ex_en;
    reg_addr_t fwd_ex_addr;
    word_t     fwd_ex_res;
    logic      fwd_mem_en;
    reg_addr_t fwd_mem_addr;
    word_t     fwd_mem_res;

    // register file model, register n holds n * 0x01010101
    assign rd1_data = {27'd0, rd1_addr} * 32'h0101_0101;
    assign rd2_data = {27'd0, rd2_addr} * 32'h0101_0101;

    decode_stage UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_ins       (pc_ins),
        .rd1_data     (rd1_data),
        .rd2_data     (rd2_data),
        .ex_en_wd     (ex_en_wd),
        .mem_en_wd    (mem_en_wd),
        .ex_des_addr  (ex_des_addr),
        .mem_des_addr (mem_des_addr),
        .ex_result    (ex_result),
        .mem_result   (mem_result),
        .en_rd1       (en_rd1),
        .en_rd2       (en_rd2),
        .rd1_addr     (rd1_addr),
        .rd2_addr     (rd2_addr),
        .num1         (num1),
        .num2         (num2),
        .op           (op),
        .sel          (sel),
        .en_wd        (en_wd),
        .des_addr     (des_addr)
    );

    decode_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_valid    (row_valid),
        .row_idx      (row_idx),
        .exp_en_rd1   (exp_en_rd1),
        .exp_en_rd2   (exp_en_rd2),
        .exp_rd1_addr (exp_rd1_addr),
        .exp_rd2_addr (exp_rd2_addr),
        .exp_num1     (exp_num1),
        .exp_num2     (exp_num2),
        .exp_op       (exp_op),
        .exp_sel      (exp_sel),
        .exp_en_wd    (exp_en_wd),
        .exp_des_addr (exp_des_addr),
        .en_rd1       (en_rd1),
        .en_rd2       (en_rd2),
        .rd1_addr     (rd1_addr),
        .rd2_addr     (rd2_addr),
        .num1         (num1),
        .num2         (num2),
        .op           (op),
        .sel          (sel),
        .en_wd        (en_wd),
        .des_addr     (des_addr),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    function automatic instr_t r_type(int rs, int rt, int rd, int sa, logic [5:0] fn);
        return {opc_special, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic instr_t i_type(logic [5:0] opc, int rs, int rt, logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t rf(int n);
        return word_t'(n) * 32'h0101_0101;  // register file contents
    endfunction

    task automatic set_fwd(logic xe, int xa, word_t xr, logic me, int ma, word_t mr);
        fwd_ex_en    = xe;
        fwd_ex_addr  = 5'(xa);
        fwd_ex_res   = xr;
        fwd_mem_en   = me;
        fwd_mem_addr = 5'(ma);
        fwd_mem_res  = mr;
    endtask

    task automatic add_row(instr_t ins, logic [1:0] rd_en, word_t n1, word_t n2,
                           alu_op_t o, alu_sel_t s, logic wd, int des);
        t_instr.push_back(ins);
        t_ex_en.push_back(fwd_ex_en);
        t_ex_addr.push_back(fwd_ex_addr);
        t_ex_res.push_back(fwd_ex_res);
        t_mem_en.push_back(fwd_mem_en);
        t_mem_addr.push_back(fwd_mem_addr);
        t_mem_res.push_back(fwd_mem_res);
        t_rd_en.push_back(rd_en);
        t_num1.push_back(n1);
        t_num2.push_back(n2);
        t_op.push_back(o);
        t_sel.push_back(s);
        t_wd.push_back(wd);
        t_des.push_back(5'(des));
    endtask

    task automatic build_table();
        set_fwd(1'b0, 0, 32'h0, 1'b0, 0, 32'h0);
        // register forms, both operands from the register file
        add_row(r_type(1, 2, 3, 0, fn_and), 2'b11, rf(1), rf(2), op_and, sel_logic, 1'b1, 3);
        add_row(r_type(5, 6, 4, 0, fn_or), 2'b11, rf(5), rf(6), op_or, sel_logic, 1'b1, 4);
        add_row(r_type(8, 9, 7, 0, fn_xor), 2'b11, rf(8), rf(9), op_xor, sel_logic, 1'b1, 7);
        add_row(r_type(11, 12, 10, 0, fn_nor), 2'b11, rf(11), rf(12), op_nor, sel_logic,
                1'b1, 10);
        add_row(r_type(14, 15, 13, 0, fn_sllv), 2'b11, rf(14), rf(15), op_sll, sel_shift,
                1'b1, 13);
        add_row(r_type(16, 17, 18, 0, fn_srlv), 2'b11, rf(16), rf(17), op_srl, sel_shift,
                1'b1, 18);
        add_row(r_type(19, 20, 21, 0, fn_srav), 2'b11, rf(19), rf(20), op_sra, sel_shift,
                1'b1, 21);
        add_row(r_type(22, 23, 24, 0, fn_add), 2'b11, rf(22), rf(23), op_add, sel_arith,
                1'b1, 24);
        add_row(r_type(25, 26, 27, 0, fn_addu), 2'b11, rf(25), rf(26), op_addu, sel_arith,
                1'b1, 27);
        add_row(r_type(28, 29, 30, 0, fn_sub), 2'b11, rf(28), rf(29), op_sub, sel_arith,
                1'b1, 30);
        add_row(r_type(31, 1, 2, 0, fn_subu), 2'b11, rf(31), rf(1), op_subu, sel_arith, 1'b1, 2);
        add_row(r_type(3, 4, 5, 0, fn_slt), 2'b11, rf(3), rf(4), op_slt, sel_arith, 1'b1, 5);
        add_row(r_type(6, 7, 8, 0, fn_sltu), 2'b11, rf(6), rf(7), op_sltu, sel_arith, 1'b1, 8);
        // immediate forms write rt, operand 2 is the immediate
        add_row(i_type(opc_andi, 1, 2, 16'h8001), 2'b10, rf(1), 32'h0000_8001, op_and,
                sel_logic, 1'b1, 2);
        add_row(i_type(opc_ori, 3, 4, 16'hF0F0), 2'b10, rf(3), 32'h0000_F0F0, op_or,
                sel_logic, 1'b1, 4);
        add_row(i_type(opc_xori, 5, 6, 16'hABCD), 2'b10, rf(5), 32'h0000_ABCD, op_xor,
                sel_logic, 1'b1, 6);
        add_row(i_type(opc_lui, 0, 7, 16'h1234), 2'b10, rf(0), 32'h1234_0000, op_or,
                sel_logic, 1'b1, 7);
        add_row(i_type(opc_addi, 8, 9, 16'h0010), 2'b10, rf(8), 32'h0000_0010, op_addi,
                sel_arith, 1'b1, 9);
        add_row(i_type(opc_addi, 10, 11, 16'hFFFC), 2'b10, rf(10), 32'hFFFF_FFFC, op_addi,
                sel_arith, 1'b1, 11);
        add_row(i_type(opc_addiu, 12, 13, 16'h8000), 2'b10, rf(12), 32'hFFFF_8000, op_addiu,
                sel_arith, 1'b1, 13);
        add_row(i_type(opc_slti, 14, 15, 16'hFFFF), 2'b10, rf(14), 32'hFFFF_FFFF, op_slt,
                sel_arith, 1'b1, 15);
        add_row(i_type(opc_sltiu, 16, 17, 16'h7FFF), 2'b10, rf(16), 32'h0000_7FFF, op_sltu,
                sel_arith, 1'b1, 17);
        // immediate shifts, shift amount lands in num1
        add_row(r_type(0, 18, 19, 4, fn_sll), 2'b01, 32'd4, rf(18), op_sll, sel_shift, 1'b1, 19);
        add_row(r_type(0, 20, 21, 31, fn_srl), 2'b01, 32'd31, rf(20), op_srl, sel_shift,
                1'b1, 21);
        add_row(r_type(0, 22, 23, 1, fn_sra), 2'b01, 32'd1, rf(22), op_sra, sel_shift, 1'b1, 23);
        // forwarding priority
        set_fwd(1'b1, 1, 32'hEEEE_0001, 1'b1, 2, 32'hDDDD_0002);
        add_row(r_type(1, 2, 3, 0, fn_add), 2'b11, 32'hEEEE_0001, 32'hDDDD_0002, op_add,
                sel_arith, 1'b1, 3);
        set_fwd(1'b1, 5, 32'hEEEE_0005, 1'b1, 5, 32'hDDDD_0005);
        add_row(r_type(5, 5, 6, 0, fn_or), 2'b11, 32'hEEEE_0005, 32'hEEEE_0005, op_or,
                sel_logic, 1'b1, 6);
        set_fwd(1'b0, 5, 32'hEEEE_0005, 1'b1, 5, 32'hDDDD_0005);  // ex blocked
        add_row(r_type(5, 5, 6, 0, fn_or), 2'b11, 32'hDDDD_0005, 32'hDDDD_0005, op_or,
                sel_logic, 1'b1, 6);
        set_fwd(1'b0, 5, 32'hEEEE_0005, 1'b0, 5, 32'hDDDD_0005);
        add_row(r_type(5, 5, 6, 0, fn_or), 2'b11, rf(5), rf(5), op_or, sel_logic, 1'b1, 6);
        set_fwd(1'b1, 8, 32'h1234_5678, 1'b1, 9, 32'hBAD0_0009);  // rt unread, imm kept
        add_row(i_type(opc_addiu, 8, 9, 16'h0001), 2'b10, 32'h1234_5678, 32'h0000_0001,
                op_addiu, sel_arith, 1'b1, 9);
        set_fwd(1'b1, 0, 32'hBAD0_0000, 1'b1, 18, 32'h0000_00F0);
        add_row(r_type(0, 18, 19, 2, fn_sll), 2'b01, 32'd2, 32'h0000_00F0, op_sll, sel_shift,
                1'b1, 19);
        // conditional moves
        set_fwd(1'b0, 0, 32'h0, 1'b0, 0, 32'h0);
        add_row(r_type(1, 2, 3, 0, fn_movn), 2'b11, rf(1), rf(2), op_movn, sel_move, 1'b1, 3);
        add_row(r_type(1, 0, 3, 0, fn_movn), 2'b11, rf(1), 32'h0, op_movn, sel_move, 1'b0, 3);
        add_row(r_type(1, 0, 4, 0, fn_movz), 2'b11, rf(1), 32'h0, op_movz, sel_move, 1'b1, 4);
        add_row(r_type(1, 2, 4, 0, fn_movz), 2'b11, rf(1), rf(2), op_movz, sel_move, 1'b0, 4);
        set_fwd(1'b1, 2, 32'h0, 1'b0, 0, 32'h0);  // forwarded zero
        add_row(r_type(1, 2, 4, 0, fn_movz), 2'b11, rf(1), 32'h0, op_movz, sel_move, 1'b1, 4);
        set_fwd(1'b0, 0, 32'h0, 1'b1, 0, 32'h5);  // $0 forwards too
        add_row(r_type(1, 0, 3, 0, fn_movn), 2'b11, rf(1), 32'h5, op_movn, sel_move, 1'b1, 3);
        // nops and unknown encodings, destination is still the rd field
        set_fwd(1'b0, 0, 32'h0, 1'b0, 0, 32'h0);
        add_row(r_type(0, 0, 0, 0, fn_sync), 2'b00, 32'h0, 32'h0, op_nop, sel_nop, 1'b0, 0);
        add_row(i_type(opc_pref, 1, 2, 16'h0004), 2'b00, 32'h0, 32'h0, op_nop, sel_nop, 1'b0, 0);
        add_row(i_type(6'h3F, 3, 4, 16'h2800), 2'b00, 32'h0, 32'h0, op_nop, sel_nop, 1'b0, 5);
        add_row(r_type(1, 2, 3, 0, 6'h18), 2'b00, 32'h0, 32'h0, op_nop, sel_nop, 1'b0, 3);
        add_row(r_type(1, 2, 3, 5, fn_and), 2'b00, 32'h0, 32'h0, op_nop, sel_nop, 1'b0, 3);
        add_row(r_type(1, 2, 3, 4, fn_sll), 2'b00, 32'h0, 32'h0, op_nop, sel_nop, 1'b0, 3);
        add_row(r_type(0, 0, 8, 0, 6'h10), 2'b00, 32'h0, 32'h0, op_nop, sel_nop, 1'b0, 8);
    endtask

    task automatic apply_row(int i);
        pc_ins       = t_instr[i];
        ex_en_wd     = t_ex_en[i];
        ex_des_addr  = t_ex_addr[i];
        ex_result    = t_ex_res[i];
        mem_en_wd    = t_mem_en[i];
        mem_des_addr = t_mem_addr[i];
        mem_result   = t_mem_res[i];
        exp_en_rd1   = t_rd_en[i][1];
        exp_en_rd2   = t_rd_en[i][0];
        exp_rd1_addr = t_instr[i][25:21];  // rs field
        exp_rd2_addr = t_instr[i][20:16];  // rt field
        exp_num1     = t_num1[i];
        exp_num2     = t_num2[i];
        exp_op       = t_op[i];
        exp_sel      = t_sel[i];
        exp_en_wd    = t_wd[i];
        exp_des_addr = t_des[i];
        row_idx      = i;
        row_valid    = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n        = 1'b0;
        pc_ins       = r_type(0, 0, 0, 0, fn_sync);
        ex_en_wd     = 1'b0;
        mem_en_wd    = 1'b0;
        ex_des_addr  = '0;
        mem_des_addr = '0;
        ex_result    = '0;
        mem_result   = '0;
        row_valid    = 1'b0;
        row_idx      = 0;
        exp_en_rd1   = 1'b0;
        exp_en_rd2   = 1'b0;
        exp_rd1_addr = '0;
        exp_rd2_addr = '0;
        exp_num1     = '0;
        exp_num2     = '0;
        exp_op       = op_nop;
        exp_sel      = sel_nop;
        exp_en_wd    = 1'b0;
        exp_des_addr = '0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < t_instr.size(); i++) begin
            apply_row(i);
            @(posedge clk);
            #1;
        end
        row_valid = 1'b0;
        pc_ins    = r_type(0, 0, 0, 0, fn_sync);
        repeat (2) @(posedge clk);  // let the last row drain
        #1;
        $display("decode_stage: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog, reset plus one cycle per row with margin
    initial begin
        wait (table_ready);
        #((t_instr.size() + 20) * 10);
        $display("timeout: the run did not finish within %0d cycles", t_instr.size() + 20);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- testbench/decode_checker.sv
module decode_checker
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      row_valid,
    input  int        row_idx,
    input  logic      exp_en_rd1,
    input  logic      exp_en_rd2,
    input  reg_addr_t exp_rd1_addr,
    input  reg_addr_t exp_rd2_addr,
    input  word_t     exp_num1,
    input  word_t     exp_num2,
    input  alu_op_t   exp_op,
    input  alu_sel_t  exp_sel,
    input  logic      exp_en_wd,
    input  reg_addr_t exp_des_addr,
    input  logic      en_rd1,
    input  logic      en_rd2,
    input  reg_addr_t rd1_addr,
    input  reg_addr_t rd2_addr,
    input  word_t     num1,
    input  word_t     num2,
    input  alu_op_t   op,
    input  alu_sel_t  sel,
    input  logic      en_wd,
    input  reg_addr_t des_addr,
    output int        error_count,
    output int        check_count
);

    logic      rst_seen;    // rst_n at the last rising edge
    logic      pend_valid;  // row captured by the stage register
    int        pend_idx;
    word_t     pend_num1;
    word_t     pend_num2;
    alu_op_t   pend_op;
    alu_sel_t  pend_sel;
    logic      pend_en_wd;
    reg_addr_t pend_des_addr;

    task automatic compare(string what, int idx, logic [31:0] got, logic [31:0] expv);
        check_count++;
        if (got !== expv) begin
            error_count++;
            $display("FAIL: time %0t: row %0d %s is %h, expected %h",
                     $time, idx, what, got, expv);
        end
    endtask

    // expected bundle follows the row through the one-cycle stage
    always @(posedge clk) begin
        rst_seen      <= rst_n;
        pend_valid    <= row_valid;
        pend_idx      <= row_idx;
        pend_num1     <= exp_num1;
        pend_num2     <= exp_num2;
        pend_op       <= exp_op;
        pend_sel      <= exp_sel;
        pend_en_wd    <= exp_en_wd;
        pend_des_addr <= exp_des_addr;
    end

    // falling edge, all outputs settled
    always @(negedge clk) begin
        if (!rst_seen) begin
            compare("reset num1", -1, num1, 32'h0);
            compare("reset num2", -1, num2, 32'h0);
            compare("reset op", -1, 32'(op), 32'(op_nop));
            compare("reset sel", -1, 32'(sel), 32'(sel_nop));
            compare("reset en_wd", -1, 32'(en_wd), 32'h0);
            compare("reset des_addr", -1, 32'(des_addr), 32'h0);
        end else if (pend_valid) begin
            compare("num1", pend_idx, num1, pend_num1);
            compare("num2", pend_idx, num2, pend_num2);
            compare("op", pend_idx, 32'(op), 32'(pend_op));
            compare("sel", pend_idx, 32'(sel), 32'(pend_sel));
            compare("en_wd", pend_idx, 32'(en_wd), 32'(pend_en_wd));
            compare("des_addr", pend_idx, 32'(des_addr), 32'(pend_des_addr));
        end
        if (row_valid) begin
            compare("en_rd1", row_idx, 32'(en_rd1), 32'(exp_en_rd1));
            compare("en_rd2", row_idx, 32'(en_rd2), 32'(exp_en_rd2));
            if (exp_en_rd1) begin
                compare("rd1_addr", row_idx, 32'(rd1_addr), 32'(exp_rd1_addr));
            end
            if (exp_en_rd2) begin
                compare("rd2_addr", row_idx, 32'(rd2_addr), 32'(exp_rd2_addr));
            end
        end
    end

endmodule

//--- src/decode_stage.sv
module decode_stage
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  instr_t    pc_ins,
    input  word_t     rd1_data,
    input  word_t     rd2_data,
    input  logic      ex_en_wd,
    input  logic      mem_en_wd,
    input  reg_addr_t ex_des_addr,
    input  reg_addr_t mem_des_addr,
    input  word_t     ex_result,
    input  word_t     mem_result,
    output logic      en_rd1,
    output logic      en_rd2,
    output reg_addr_t rd1_addr,
    output reg_addr_t rd2_addr,
    output word_t     num1,
    output word_t     num2,
    output alu_op_t   op,
    output alu_sel_t  sel,
    output logic      en_wd,
    output reg_addr_t des_addr
);

    word_t      imm;
    alu_op_t    ctl_op;
    alu_sel_t   ctl_sel;
    logic       wd_req;
    move_cond_t move_cond;
    reg_addr_t  ctl_des_addr;
    word_t      num1_sel;
    word_t      num2_sel;

    id_control u_control (
        .pc_ins    (pc_ins),
        .en_rd1    (en_rd1),
        .en_rd2    (en_rd2),
        .rd1_addr  (rd1_addr),
        .rd2_addr  (rd2_addr),
        .imm       (imm),
        .op        (ctl_op),
        .sel       (ctl_sel),
        .wd_req    (wd_req),
        .move_cond (move_cond),
        .des_addr  (ctl_des_addr)
    );

    operand_select u_sel1 (  // rs side
        .en_rd        (en_rd1),
        .rd_addr      (rd1_addr),
        .rd_data      (rd1_data),
        .imm          (imm),
        .ex_en_wd     (ex_en_wd),
        .ex_des_addr  (ex_des_addr),
        .ex_result    (ex_result),
        .mem_en_wd    (mem_en_wd),
        .mem_des_addr (mem_des_addr),
        .mem_result   (mem_result),
        .num          (num1_sel)
    );

    operand_select u_sel2 (  // rt side
        .en_rd        (en_rd2),
        .rd_addr      (rd2_addr),
        .rd_data      (rd2_data),
        .imm          (imm),
        .ex_en_wd     (ex_en_wd),
        .ex_des_addr  (ex_des_addr),
        .ex_result    (ex_result),
        .mem_en_wd    (mem_en_wd),
        .mem_des_addr (mem_des_addr),
        .mem_result   (mem_result),
        .num          (num2_sel)
    );

    id_ex_reg u_id_ex (
        .clk         (clk),
        .rst_n       (rst_n),
        .num1_in     (num1_sel),
        .num2_in     (num2_sel),
        .op_in       (ctl_op),
        .sel_in      (ctl_sel),
        .wd_req      (wd_req),
        .move_cond   (move_cond),
        .des_addr_in (ctl_des_addr),
        .num1        (num1),
        .num2        (num2),
        .op          (op),
        .sel         (sel),
        .en_wd       (en_wd),
        .des_addr    (des_addr)
    );

endmodule

//--- src/id_ex_reg.sv
module id_ex_reg
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  word_t      num1_in,
    input  word_t      num2_in,
    input  alu_op_t    op_in,
    input  alu_sel_t   sel_in,
    input  logic       wd_req,
    input  move_cond_t move_cond,
    input  reg_addr_t  des_addr_in,
    output word_t      num1,
    output word_t      num2,
    output alu_op_t    op,
    output alu_sel_t   sel,
    output logic       en_wd,
    output reg_addr_t  des_addr
);

    logic cond_ok;
    logic en_wd_next;

    // movn/movz decide on the forwarded operand 2
    always_comb begin
        case (move_cond)
            mc_always:  cond_ok = 1'b1;
            mc_nonzero: cond_ok = (num2_in != '0);
            mc_zero:    cond_ok = (num2_in == '0);
            default:    cond_ok = 1'b0;
        endcase
    end

    assign en_wd_next = wd_req && cond_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            num1     <= '0;
            num2     <= '0;
            op       <= op_nop;
            sel      <= sel_nop;
            en_wd    <= 1'b0;
            des_addr <= '0;
        end else begin
            num1     <= num1_in;
            num2     <= num2_in;
            op       <= op_in;
            sel      <= sel_in;
            en_wd    <= en_wd_next;
            des_addr <= des_addr_in;
        end
    end

    // a nop bundle leaving decode never writes the gpr
    a_nop_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sel == sel_nop) |-> !en_wd
    );

endmodule

//--- src/operand_select.sv
module operand_select
    import decode_pkg::*;
(
    input  logic      en_rd,
    input  reg_addr_t rd_addr,
    input  word_t     rd_data,
    input  word_t     imm,
    input  logic      ex_en_wd,
    input  reg_addr_t ex_des_addr,
    input  word_t     ex_result,
    input  logic      mem_en_wd,
    input  reg_addr_t mem_des_addr,
    input  word_t     mem_result,
    output word_t     num
);

    logic ex_hit;
    logic mem_hit;

    // no special case for $0, matches the pipeline's forwarding rule
    assign ex_hit  = en_rd && ex_en_wd && (rd_addr == ex_des_addr);
    assign mem_hit = en_rd && mem_en_wd && (rd_addr == mem_des_addr);

    always_comb begin
        if (ex_hit) begin
            num = ex_result;   // newest value wins
        end else if (mem_hit) begin
            num = mem_result;
        end else if (en_rd) begin
            num = rd_data;
        end else begin
            num = imm;         // port unused, operand is the immediate
        end
    end

endmodule

//--- src/id_control.sv
module id_control
    import decode_pkg::*;
(
    input  instr_t     pc_ins,
    output logic       en_rd1,
    output logic       en_rd2,
    output reg_addr_t  rd1_addr,
    output reg_addr_t  rd2_addr,
    output word_t      imm,
    output alu_op_t    op,
    output alu_sel_t   sel,
    output logic       wd_req,
    output move_cond_t move_cond,
    output reg_addr_t  des_addr
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  sa;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm16;
    logic        shift_imm_form;

    assign opcode = pc_ins[31:26];
    assign rs     = pc_ins[25:21];
    assign rt     = pc_ins[20:16];
    assign rd     = pc_ins[15:11];
    assign sa     = pc_ins[10:6];
    assign funct  = pc_ins[5:0];
    assign imm16  = pc_ins[15:0];

    // sll/srl/sra carry opcode and rs all zero
    assign shift_imm_form = (pc_ins[31:21] == 11'd0);

    always_comb begin
        logic i_form;  // rs op imm -> rt

        i_form    = 1'b0;
        en_rd1    = 1'b0;
        en_rd2    = 1'b0;
        rd1_addr  = rs;
        rd2_addr  = rt;
        imm       = '0;
        op        = op_nop;
        sel       = sel_nop;
        wd_req    = 1'b0;
        move_cond = mc_always;
        des_addr  = rd;  // rd unless immediate form

        case (opcode)
            opc_special: begin
                if (sa == 5'd0) begin
                    case (funct)
                        fn_and:  begin op = op_and;  sel = sel_logic; end
                        fn_or:   begin op = op_or;   sel = sel_logic; end
                        fn_xor:  begin op = op_xor;  sel = sel_logic; end
                        fn_nor:  begin op = op_nor;  sel = sel_logic; end
                        fn_sllv: begin op = op_sll;  sel = sel_shift; end  // same op as sll
                        fn_srlv: begin op = op_srl;  sel = sel_shift; end
                        fn_srav: begin op = op_sra;  sel = sel_shift; end
                        fn_add:  begin op = op_add;  sel = sel_arith; end
                        fn_addu: begin op = op_addu; sel = sel_arith; end
                        fn_sub:  begin op = op_sub;  sel = sel_arith; end
                        fn_subu: begin op = op_subu; sel = sel_arith; end
                        fn_slt:  begin op = op_slt;  sel = sel_arith; end
                        fn_sltu: begin op = op_sltu; sel = sel_arith; end
                        fn_movn: begin
                            op        = op_movn;
                            sel       = sel_move;
                            move_cond = mc_nonzero;  // write only if rt != 0
                        end
                        fn_movz: begin
                            op        = op_movz;
                            sel       = sel_move;
                            move_cond = mc_zero;     // write only if rt == 0
                        end
                        fn_sync: op = op_nop;        // treated as nop
                        default: op = op_nop;
                    endcase
                    // every kept register form reads rs and rt
                    if (sel != sel_nop) begin
                        en_rd1 = 1'b1;
                        en_rd2 = 1'b1;
                        wd_req = 1'b1;
                    end
                end

                if (shift_imm_form) begin
                    case (funct)
                        fn_sll: begin
                            en_rd2 = 1'b1;
                            wd_req = 1'b1;
                            op     = op_sll;
                            sel    = sel_shift;
                            imm    = {27'd0, sa};  // shift amount into num1
                        end
                        fn_srl: begin
                            en_rd2 = 1'b1;
                            wd_req = 1'b1;
                            op     = op_srl;
                            sel    = sel_shift;
                            imm    = {27'd0, sa};
                        end
                        fn_sra: begin
                            en_rd2 = 1'b1;
                            wd_req = 1'b1;
                            op     = op_sra;
                            sel    = sel_shift;
                            imm    = {27'd0, sa};
                        end
                        default: imm = '0;
                    endcase
                end
            end

            opc_andi: begin
                i_form = 1'b1;
                op     = op_and;
                sel    = sel_logic;
                imm    = {16'd0, imm16};  // zero extend
            end
            opc_ori: begin
                i_form = 1'b1;
                op     = op_or;
                sel    = sel_logic;
                imm    = {16'd0, imm16};
            end
            opc_xori: begin
                i_form = 1'b1;
                op     = op_xor;
                sel    = sel_logic;
                imm    = {16'd0, imm16};
            end
            opc_lui: begin
                i_form = 1'b1;
                op     = op_or;              // or with rs, normally $0
                sel    = sel_logic;
                imm    = {imm16, 16'd0};
            end
            opc_addi: begin
                i_form = 1'b1;
                op     = op_addi;
                sel    = sel_arith;
                imm    = {{16{imm16[15]}}, imm16};  // sign extend
            end
            opc_addiu: begin
                i_form = 1'b1;
                op     = op_addiu;
                sel    = sel_arith;
                imm    = {{16{imm16[15]}}, imm16};
            end
            opc_slti: begin
                i_form = 1'b1;
                op     = op_slt;
                sel    = sel_arith;
                imm    = {{16{imm16[15]}}, imm16};
            end
            opc_sltiu: begin
                i_form = 1'b1;
                op     = op_sltu;
                sel    = sel_arith;
                imm    = {{16{imm16[15]}}, imm16};
            end
            opc_pref: op = op_nop;  // prefetch hint, nothing to do
            default:  op = op_nop;
        endcase

        if (i_form) begin
            en_rd1   = 1'b1;
            wd_req   = 1'b1;
            des_addr = rt;
        end

        // a nop must not hold a register-file port
        a_nop_no_read: assert (op != op_nop || (!en_rd1 && !en_rd2));
    end

endmodule

//--- src/decode_pkg.sv
package decode_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 8;
    localparam int alu_sel_w  = 3;

    typedef logic [data_w-1:0]     word_t;
    typedef logic [data_w-1:0]     instr_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [alu_op_w-1:0]   alu_op_t;
    typedef logic [alu_sel_w-1:0]  alu_sel_t;  // result class, nop means no gpr write
    typedef logic [1:0]            move_cond_t;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] opc_special = 6'b000000;
    localparam logic [5:0] opc_andi    = 6'b001100;
    localparam logic [5:0] opc_ori     = 6'b001101;
    localparam logic [5:0] opc_xori    = 6'b001110;
    localparam logic [5:0] opc_lui     = 6'b001111;
    localparam logic [5:0] opc_pref    = 6'b110011;
    localparam logic [5:0] opc_addi    = 6'b001000;
    localparam logic [5:0] opc_addiu   = 6'b001001;
    localparam logic [5:0] opc_slti    = 6'b001010;
    localparam logic [5:0] opc_sltiu   = 6'b001011;

    // function codes, instr[5:0] under special
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_sllv = 6'b000100;
    localparam logic [5:0] fn_srlv = 6'b000110;
    localparam logic [5:0] fn_srav = 6'b000111;
    localparam logic [5:0] fn_sync = 6'b001111;
    localparam logic [5:0] fn_movn = 6'b001011;
    localparam logic [5:0] fn_movz = 6'b001010;
    localparam logic [5:0] fn_add  = 6'b100000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_sub  = 6'b100010;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    // execute operation codes
    localparam alu_op_t op_nop   = 8'b0000_0000;
    localparam alu_op_t op_and   = 8'b0010_0100;
    localparam alu_op_t op_or    = 8'b0010_0101;
    localparam alu_op_t op_xor   = 8'b0010_0110;
    localparam alu_op_t op_nor   = 8'b0010_0111;
    localparam alu_op_t op_sll   = 8'b0111_1100;
    localparam alu_op_t op_srl   = 8'b0000_0010;
    localparam alu_op_t op_sra   = 8'b0000_0011;
    localparam alu_op_t op_movn  = 8'b0000_1011;
    localparam alu_op_t op_movz  = 8'b0000_1010;
    localparam alu_op_t op_add   = 8'b0010_0000;
    localparam alu_op_t op_addu  = 8'b0010_0001;
    localparam alu_op_t op_sub   = 8'b0010_0010;
    localparam alu_op_t op_subu  = 8'b0010_0011;
    localparam alu_op_t op_slt   = 8'b0010_1010;
    localparam alu_op_t op_sltu  = 8'b0010_1011;
    localparam alu_op_t op_addi  = 8'b0101_0101;
    localparam alu_op_t op_addiu = 8'b0101_0110;

    // result classes
    localparam alu_sel_t sel_nop   = 3'b000;
    localparam alu_sel_t sel_logic = 3'b001;
    localparam alu_sel_t sel_shift = 3'b010;
    localparam alu_sel_t sel_move  = 3'b011;
    localparam alu_sel_t sel_arith = 3'b100;

    // write-back condition, movn/movz depend on operand 2
    localparam move_cond_t mc_always  = 2'b00;
    localparam move_cond_t mc_nonzero = 2'b01;
    localparam move_cond_t mc_zero    = 2'b10;

endpackage
